/* core.f */
common/core_pkg.sv
verilog/pipereg.sv
pipeline/fetch.sv
pipeline/decode.sv
pipeline/regfile.sv
pipeline/execute.sv
pipeline/memory.sv
verilog/core.sv
verif/tb_clock.sv
verif/core_tb.sv

/* Bender.yml */
package:
  name: core

sources:
  - common/core_pkg.sv
  - verilog/pipereg.sv
  - pipeline/fetch.sv
  - pipeline/decode.sv
  - pipeline/regfile.sv
  - pipeline/execute.sv
  - pipeline/memory.sv
  - verilog/core.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/core_tb.sv

/* verif/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

	localparam int n_prog = 64;
	localparam logic [63:0] prog_base = 64'h0000_0000_8000_0000;

	logic clk;
	logic arst_n;
	logic ireq_valid;
	core_pkg::u64 ireq_addr;
	core_pkg::u32 iresp_data;
	logic dreq_valid;
	logic dreq_write;
	core_pkg::u64 dreq_addr;
	core_pkg::word_t dreq_wdata;
	core_pkg::word_t dresp_data;
	logic commit_valid;
	core_pkg::u64 commit_pc;
	core_pkg::u32 commit_instr;
	logic commit_wen;
	core_pkg::creg_addr_t commit_wdest;
	core_pkg::word_t commit_wdata;

	logic [31:0] lfsr = 32'h27ffc268;
	core_pkg::u32 prog [0:n_prog-1];
	logic exp_wen [0:n_prog-1];
	logic [4:0] exp_wdest [0:n_prog-1];
	core_pkg::word_t exp_wdata [0:n_prog-1];
	// data requests in program order
	logic exp_mwrite [0:n_prog-1];
	logic [63:0] exp_maddr [0:n_prog-1];
	core_pkg::word_t exp_mwdata [0:n_prog-1];
	core_pkg::word_t dmem [0:31];
	core_pkg::word_t mregs [0:31];
	core_pkg::word_t mmem [0:31];
	int mem_count = 0;
	int mem_idx = 0;
	int ci = 0;
	int prog_commits = 0;
	int mismatches = 0;
	int failures = 0;
	logic rst_done = 1'b0;
	logic fetch_seen = 1'b0;
	logic [63:0] last_fetch;

	tb_clock clock_i (.clk, .arst_n);

	core core_i (.*);

	// both buses answer in the request cycle
	always_comb begin
		iresp_data = 32'h0000_0013;
		if (ireq_valid && ireq_addr >= prog_base && ireq_addr < prog_base + 4 * n_prog) begin
			iresp_data = prog[(ireq_addr - prog_base) >> 2];
		end
	end

	always_comb begin
		dresp_data = (dreq_valid && !dreq_write) ? dmem[dreq_addr[7:3]] : '0;
	end

	always @(posedge clk) begin
		if (dreq_valid && dreq_write) begin
			dmem[dreq_addr[7:3]] <= dreq_wdata;
		end
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// never a register written by the two previous instructions
	function automatic logic [4:0] pick_src(input logic [4:0] w1, input logic [4:0] w2);
		logic [4:0] r;
		do begin
			r = rand_bits(5);
		end while (r != 0 && (r == w1 || r == w2));
		return r;
	endfunction

	function automatic core_pkg::word_t fill_word(input int idx);
		logic [31:0] a;
		a = idx * 8;
		return {a ^ 32'hc0de_0000, ~a};
	endfunction

	task automatic build_program();
		int sel;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] w1;
		logic [4:0] w2;
		logic [11:0] imm12;
		logic [19:0] imm20;
		logic [7:0] off;
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t res;
		logic wen;
		w1 = 0;
		w2 = 0;
		for (int i = 0; i < n_prog; i++) begin
			do begin
				sel = rand_bits(4);
			end while (sel > 8);
			rd = rand_bits(5);
			rs1 = pick_src(w1, w2);
			rs2 = pick_src(w1, w2);
			imm12 = rand_bits(12);
			imm20 = rand_bits(20);
			off = {rand_bits(5), 3'b000};
			a = mregs[rs1];
			b = mregs[rs2];
			wen = 1'b1;
			case (sel)
				0: begin
					prog[i] = {imm12, rs1, 3'b000, rd, 7'b0010011};
					res = a + {{52{imm12[11]}}, imm12};
				end
				1: begin
					prog[i] = {imm20, rd, 7'b0110111};
					res = {{32{imm20[19]}}, imm20, 12'h000};
				end
				2: begin
					prog[i] = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
					res = a + b;
				end
				3: begin
					prog[i] = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
					res = a - b;
				end
				4: begin
					prog[i] = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
					res = a & b;
				end
				5: begin
					prog[i] = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
					res = a | b;
				end
				6: begin
					prog[i] = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
					res = a ^ b;
				end
				7: begin
					// ld off(x0)
					prog[i] = {4'b0000, off, 5'd0, 3'b011, rd, 7'b0000011};
					res = mmem[off[7:3]];
					exp_mwrite[mem_count] = 1'b0;
					exp_maddr[mem_count] = {56'd0, off};
					mem_count++;
				end
				default: begin
					// sd rs2, off(x0)
					prog[i] = {4'b0000, off[7:5], rs2, 5'd0, 3'b011, off[4:0], 7'b0100011};
					res = '0;
					wen = 1'b0;
					mmem[off[7:3]] = b;
					exp_mwrite[mem_count] = 1'b1;
					exp_maddr[mem_count] = {56'd0, off};
					exp_mwdata[mem_count] = b;
					mem_count++;
				end
			endcase
			wen = wen && rd != 0;
			if (wen) begin
				mregs[rd] = res;
			end
			exp_wen[i] = wen;
			exp_wdest[i] = rd;
			exp_wdata[i] = res;
			w2 = w1;
			w1 = wen ? rd : 5'd0;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		mismatches++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	endtask

	task automatic report_failure(input string msg);
		failures++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!rst_done) begin
			if (commit_valid !== 1'b0) report_failure("commit_valid high during reset");
			if (dreq_valid !== 1'b0) report_failure("dreq_valid high during reset");
			// flops leave reset at the next rising edge
			if (arst_n) begin
				rst_done = 1'b1;
			end
		end else begin
			if (!fetch_seen && ireq_valid !== 1'b1) begin
				report_failure("ireq_valid low in the first cycle after reset");
			end
			if (ireq_valid) begin
				if (!fetch_seen && ireq_addr !== prog_base) begin
					report_mismatch("ireq_addr", ireq_addr, prog_base);
				end
				if (fetch_seen && ireq_addr !== last_fetch + 4) begin
					report_mismatch("ireq_addr", ireq_addr, last_fetch + 4);
				end
				last_fetch = ireq_addr;
			end
			fetch_seen = 1'b1;
			if (dreq_valid) begin
				if (mem_idx >= mem_count) begin
					report_failure("data request with no matching load or store");
				end else begin
					if (dreq_write !== exp_mwrite[mem_idx]) begin
						report_mismatch("dreq_write", dreq_write, exp_mwrite[mem_idx]);
					end
					if (dreq_addr !== exp_maddr[mem_idx]) begin
						report_mismatch("dreq_addr", dreq_addr, exp_maddr[mem_idx]);
					end
					if (exp_mwrite[mem_idx] && dreq_wdata !== exp_mwdata[mem_idx]) begin
						report_mismatch("dreq_wdata", dreq_wdata, exp_mwdata[mem_idx]);
					end
				end
				mem_idx++;
			end
			if (commit_valid) begin
				if (commit_pc !== prog_base + 64'(4 * ci)) begin
					report_mismatch("commit_pc", commit_pc, prog_base + 64'(4 * ci));
				end
				if (ci < n_prog) begin
					if (commit_instr !== prog[ci]) begin
						report_mismatch("commit_instr", commit_instr, prog[ci]);
					end
					if (commit_wen !== exp_wen[ci]) begin
						report_mismatch("commit_wen", commit_wen, exp_wen[ci]);
					end
					if (exp_wen[ci] && commit_wdest !== exp_wdest[ci]) begin
						report_mismatch("commit_wdest", commit_wdest, exp_wdest[ci]);
					end
					if (exp_wen[ci] && commit_wdata !== exp_wdata[ci]) begin
						report_mismatch("commit_wdata", commit_wdata, exp_wdata[ci]);
					end
					prog_commits++;
				end else if (commit_wen !== 1'b0) begin
					report_mismatch("commit_wen", commit_wen, 1'b0);
				end
				ci++;
			end
		end
	end

	initial begin
		for (int i = 0; i < 32; i++) begin
			dmem[i] = fill_word(i);
			mmem[i] = fill_word(i);
			mregs[i] = '0;
		end
		build_program();
		while (prog_commits < n_prog) @(negedge clk);
		repeat (2) @(negedge clk);
		if (mem_idx != mem_count) begin
			report_failure("number of data requests differs from the program");
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// program length plus reset plus pipeline drain
	initial begin
		#((n_prog + 3 + 20) * 10);
		$display("no commit for every program instruction: %0d of %0d committed",
			prog_commits, n_prog);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held over the first three rising edges
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

/* verilog/core.sv */
`timescale 1ns/1ps

module core (
	input  logic                 clk,
	input  logic                 arst_n,
	// instruction bus
	output logic                 ireq_valid,
	output core_pkg::u64         ireq_addr,
	input  core_pkg::u32         iresp_data,
	// data bus
	output logic                 dreq_valid,
	output logic                 dreq_write,
	output core_pkg::u64         dreq_addr,
	output core_pkg::word_t      dreq_wdata,
	input  core_pkg::word_t      dresp_data,
	// retired instructions
	output logic                 commit_valid,
	output core_pkg::u64         commit_pc,
	output core_pkg::u32         commit_instr,
	output logic                 commit_wen,
	output core_pkg::creg_addr_t commit_wdest,
	output core_pkg::word_t      commit_wdata
);

	core_pkg::fetch_data_t   data_f_nxt;
	core_pkg::fetch_data_t   data_f;
	core_pkg::decode_data_t  data_d_nxt;
	core_pkg::decode_data_t  data_d;
	core_pkg::execute_data_t data_e_nxt;
	core_pkg::execute_data_t data_e;
	core_pkg::memory_data_t  data_m_nxt;
	core_pkg::memory_data_t  data_w;

	core_pkg::creg_addr_t ra1;
	core_pkg::creg_addr_t ra2;
	core_pkg::word_t      rd1;
	core_pkg::word_t      rd2;

	fetch fetch_i (
		.clk,
		.arst_n,
		.ireq_valid,
		.ireq_addr,
		.iresp_data,
		.data_f(data_f_nxt)
	);

	pipereg #(.T(core_pkg::fetch_data_t)) dreg (
		.clk,
		.arst_n,
		.in(data_f_nxt),
		.out(data_f)
	);

	decode decode_i (
		.data_f,
		.ra1,
		.ra2,
		.rd1,
		.rd2,
		.data_d(data_d_nxt)
	);

	// written from the W register, read from decode
	regfile regfile_i (
		.clk,
		.arst_n,
		.ra1,
		.ra2,
		.rd1,
		.rd2,
		.wvalid(data_w.regwrite),
		.wa(data_w.dst),
		.wd(data_w.result)
	);

	pipereg #(.T(core_pkg::decode_data_t)) ereg (
		.clk,
		.arst_n,
		.in(data_d_nxt),
		.out(data_d)
	);

	execute execute_i (
		.data_d,
		.data_e(data_e_nxt)
	);

	pipereg #(.T(core_pkg::execute_data_t)) mreg (
		.clk,
		.arst_n,
		.in(data_e_nxt),
		.out(data_e)
	);

	memory memory_i (
		.data_e,
		.dreq_valid,
		.dreq_write,
		.dreq_addr,
		.dreq_wdata,
		.dresp_data,
		.data_m(data_m_nxt)
	);

	pipereg #(.T(core_pkg::memory_data_t)) wreg (
		.clk,
		.arst_n,
		.in(data_m_nxt),
		.out(data_w)
	);

	assign commit_valid = data_w.valid;
	assign commit_pc    = data_w.pc;
	assign commit_instr = data_w.raw_instr;
	assign commit_wen   = data_w.regwrite;
	assign commit_wdest = data_w.dst;
	assign commit_wdata = data_w.result;

endmodule

/* pipeline/memory.sv */
`timescale 1ns/1ps

module memory (
	input  core_pkg::execute_data_t data_e,
	output logic                    dreq_valid,
	output logic                    dreq_write,
	output core_pkg::u64            dreq_addr,
	output core_pkg::word_t         dreq_wdata,
	input  core_pkg::word_t         dresp_data,
	output core_pkg::memory_data_t  data_m
);

	logic is_load;
	logic is_store;

	assign is_load  = data_e.valid && data_e.ctl.memread;
	assign is_store = data_e.valid && data_e.ctl.memwrite;

	assign dreq_valid = is_load || is_store;
	assign dreq_write = is_store;
	assign dreq_addr  = data_e.alu_out;
	assign dreq_wdata = data_e.store_data;

	// doubleword access only, offsets come from the immediate
	always_comb begin
		assert final (!dreq_valid || dreq_addr[2:0] == 3'b000)
			else $error("misaligned data access at %h", dreq_addr);
	end

	assign data_m.valid     = data_e.valid;
	assign data_m.pc        = data_e.pc;
	assign data_m.raw_instr = data_e.raw_instr;
	assign data_m.regwrite  = data_e.valid && data_e.ctl.regwrite;
	assign data_m.dst       = data_e.dst;
	// load data arrives in the request cycle
	assign data_m.result    = is_load ? dresp_data : data_e.alu_out;

endmodule

/* pipeline/execute.sv */
`timescale 1ns/1ps

module execute (
	input  core_pkg::decode_data_t  data_d,
	output core_pkg::execute_data_t data_e
);

	core_pkg::word_t opa;
	core_pkg::word_t opb;
	core_pkg::word_t alu_out;

	assign opa = data_d.srca;
	assign opb = data_d.ctl.alusrc_imm ? data_d.imm : data_d.srcb;

	// loads and stores come through here as add for the address
	always_comb begin
		case (data_d.ctl.alu_op)
			core_pkg::alu_add:    alu_out = opa + opb;
			core_pkg::alu_sub:    alu_out = opa - opb;
			core_pkg::alu_and:    alu_out = opa & opb;
			core_pkg::alu_or:     alu_out = opa | opb;
			core_pkg::alu_xor:    alu_out = opa ^ opb;
			core_pkg::alu_pass_b: alu_out = opb;
			default:              alu_out = opa + opb;
		endcase
	end

	assign data_e.valid      = data_d.valid;
	assign data_e.pc         = data_d.pc;
	assign data_e.raw_instr  = data_d.raw_instr;
	assign data_e.ctl        = data_d.ctl;
	assign data_e.dst        = data_d.dst;
	assign data_e.alu_out    = alu_out;
	// rs2 value is the sd payload
	assign data_e.store_data = data_d.srcb;

endmodule

/* pipeline/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic                 clk,
	input  logic                 arst_n,
	input  core_pkg::creg_addr_t ra1,
	input  core_pkg::creg_addr_t ra2,
	output core_pkg::word_t      rd1,
	output core_pkg::word_t      rd2,
	input  logic                 wvalid,
	input  core_pkg::creg_addr_t wa,
	input  core_pkg::word_t      wd
);

	// x0 has no storage
	core_pkg::word_t regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wvalid && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// read-through of the write in flight this cycle
	assign rd1 = (ra1 == '0) ? '0 : (wvalid && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (wvalid && wa == ra2) ? wd : regs[ra2];

	// decode must drop regwrite for rd = x0 all the way down the pipe
	no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
		wvalid |-> wa != '0)
		else $error("register write addressed to x0");

endmodule

/* pipeline/decode.sv */
`timescale 1ns/1ps

module decode (
	input  core_pkg::fetch_data_t  data_f,
	output core_pkg::creg_addr_t   ra1,
	output core_pkg::creg_addr_t   ra2,
	input  core_pkg::word_t        rd1,
	input  core_pkg::word_t        rd2,
	output core_pkg::decode_data_t data_d
);

	core_pkg::u32         instr;
	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	core_pkg::creg_addr_t rd;
	core_pkg::word_t      imm_i;
	core_pkg::word_t      imm_s;
	core_pkg::word_t      imm_u;
	core_pkg::word_t      imm;
	core_pkg::control_t   ctl;
	logic                 supported;

	assign instr  = data_f.raw_instr;
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign ra1    = instr[19:15];
	assign ra2    = instr[24:20];

	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};

	always_comb begin
		ctl        = '0;
		ctl.alu_op = core_pkg::alu_add;
		imm        = imm_i;
		supported  = 1'b0;
		case (opcode)
			core_pkg::op_imm: begin
				// addi only
				supported      = (funct3 == core_pkg::f3_addsub);
				ctl.regwrite   = supported;
				ctl.alusrc_imm = 1'b1;
			end
			core_pkg::op_reg: begin
				supported    = 1'b1;
				ctl.regwrite = 1'b1;
				case ({funct7, funct3})
					{core_pkg::f7_base, core_pkg::f3_addsub}: ctl.alu_op = core_pkg::alu_add;
					{core_pkg::f7_sub, core_pkg::f3_addsub}:  ctl.alu_op = core_pkg::alu_sub;
					{core_pkg::f7_base, core_pkg::f3_xor}:    ctl.alu_op = core_pkg::alu_xor;
					{core_pkg::f7_base, core_pkg::f3_or}:     ctl.alu_op = core_pkg::alu_or;
					{core_pkg::f7_base, core_pkg::f3_and}:    ctl.alu_op = core_pkg::alu_and;
					default: begin
						supported    = 1'b0;
						ctl.regwrite = 1'b0;
					end
				endcase
			end
			core_pkg::op_lui: begin
				supported      = 1'b1;
				ctl.regwrite   = 1'b1;
				ctl.alusrc_imm = 1'b1;
				ctl.alu_op     = core_pkg::alu_pass_b;
				imm            = imm_u;
			end
			core_pkg::op_load: begin
				supported      = (funct3 == core_pkg::f3_double);
				ctl.regwrite   = supported;
				ctl.memread    = supported;
				ctl.alusrc_imm = 1'b1;
			end
			core_pkg::op_store: begin
				supported      = (funct3 == core_pkg::f3_double);
				ctl.memwrite   = supported;
				ctl.alusrc_imm = 1'b1;
				imm            = imm_s;
			end
			default: begin
				supported = 1'b0;
			end
		endcase
		// x0 is never written
		if (rd == '0) begin
			ctl.regwrite = 1'b0;
		end
	end

	always_comb begin
		assert final (!data_f.valid || supported)
			else $error("unsupported instruction %h at pc %h", instr, data_f.pc);
	end

	assign data_d.valid     = data_f.valid;
	assign data_d.pc        = data_f.pc;
	assign data_d.raw_instr = instr;
	assign data_d.ctl       = ctl;
	assign data_d.dst       = rd;
	assign data_d.srca      = rd1;
	assign data_d.srcb      = rd2;
	assign data_d.imm       = imm;

endmodule

/* pipeline/fetch.sv */
`timescale 1ns/1ps

module fetch (
	input  logic                  clk,
	input  logic                  arst_n,
	output logic                  ireq_valid,
	output core_pkg::u64          ireq_addr,
	input  core_pkg::u32          iresp_data,
	output core_pkg::fetch_data_t data_f
);

	core_pkg::u64 pc;
	logic         running;

	// pc holds at the reset vector until the first fetch goes out
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			running <= 1'b0;
			pc      <= core_pkg::pc_reset;
		end else begin
			running <= 1'b1;
			if (running) begin
				pc <= pc + 64'd4;
			end
		end
	end

	assign ireq_valid = running;
	assign ireq_addr  = pc;

	// bus answers in the same cycle
	assign data_f.valid     = running;
	assign data_f.pc        = pc;
	assign data_f.raw_instr = iresp_data;

endmodule

/* verilog/pipereg.sv */
`timescale 1ns/1ps

module pipereg #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic arst_n,
	input  T     in,
	output T     out
);

	// all zeros is an invalid bubble for every stage bundle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out <= '0;
		end else begin
			out <= in;
		end
	end

endmodule

/* common/core_pkg.sv */
package core_pkg;

	localparam int xlen = 64;

	typedef logic [63:0] u64;
	typedef logic [31:0] u32;
	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] creg_addr_t;

	// first fetch address after reset
	localparam u64 pc_reset = 64'h0000_0000_8000_0000;

	// major opcodes
	localparam logic [6:0] op_imm   = 7'b0010011;
	localparam logic [6:0] op_reg   = 7'b0110011;
	localparam logic [6:0] op_lui   = 7'b0110111;
	localparam logic [6:0] op_load  = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	// funct3 values
	localparam logic [2:0] f3_addsub = 3'b000;
	localparam logic [2:0] f3_xor    = 3'b100;
	localparam logic [2:0] f3_or     = 3'b110;
	localparam logic [2:0] f3_and    = 3'b111;
	// doubleword width for ld and sd
	localparam logic [2:0] f3_double = 3'b011;

	// funct7 values for register-register ops
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_sub  = 7'b0100000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_t;

	typedef struct packed {
		logic    regwrite;
		logic    memread;
		logic    memwrite;
		logic    alusrc_imm;
		alu_op_t alu_op;
	} control_t;

	typedef struct packed {
		logic valid;
		u64   pc;
		u32   raw_instr;
	} fetch_data_t;

	typedef struct packed {
		logic       valid;
		u64         pc;
		u32         raw_instr;
		control_t   ctl;
		creg_addr_t dst;
		word_t      srca;
		word_t      srcb;
		word_t      imm;
	} decode_data_t;

	typedef struct packed {
		logic       valid;
		u64         pc;
		u32         raw_instr;
		control_t   ctl;
		creg_addr_t dst;
		word_t      alu_out;
		word_t      store_data;
	} execute_data_t;

	typedef struct packed {
		logic       valid;
		u64         pc;
		u32         raw_instr;
		logic       regwrite;
		creg_addr_t dst;
		word_t      result;
	} memory_data_t;

endpackage
